// ==== logic/capture_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module capture_buffer #(
    parameter int ADDR_W = 8
) (
    input  logic                            clk,
    input  scope_pkg::capture_wr_t          wr,
    input  logic [ADDR_W-1:0]               rd_addr,
    output logic [scope_pkg::SAMPLE_W-1:0]  rd_data
);

    import scope_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    ////////////////////////////////////////////////////////////////////////////
    // Sample memory
    ////////////////////////////////////////////////////////////////////////////

    // Contents unknown until the first capture
    logic [SAMPLE_W-1:0] mem [0:DEPTH-1];

    // Trigger side write port
    always_ff @(posedge clk) begin
        if (wr.en)
            mem[wr.addr] <= wr.code;
    end

    // Display side read port, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== logic/edge_trigger.sv ====
`timescale 1ns/1ns
`default_nettype none

module edge_trigger #(
    parameter int HYST   = 300,
    parameter int ADDR_W = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  scope_pkg::adc_sample_t          tick,
    input  logic                            enable,
    input  logic signed [scope_pkg::SAMPLE_W-1:0] trig_level,
    input  logic [10:0]                     vcount,
    output scope_pkg::capture_wr_t          wr,
    output logic                            capture_done
);

    import scope_pkg::*;

    // Two guard bits for signed threshold math
    localparam int TH_W = SAMPLE_W + 2;

    trig_state_t                state;
    logic [ADDR_W-1:0]          addr_cnt;
    logic signed [TH_W-1:0]     hi_th;
    logic signed [TH_W-1:0]     lo_th;
    logic signed [TH_W-1:0]     code_s;
    logic                       step;
    logic                       in_blank;
    logic                       last;
    logic                       fire;
    logic                       wr_en;
    logic [ADDR_W-1:0]          wr_addr;
    logic [SAMPLE_W-1:0]        wr_code;

    ////////////////////////////////////////////////////////////////////////////
    // Thresholds and qualifiers
    ////////////////////////////////////////////////////////////////////////////

    // High threshold sits trig_level codes off mid-scale
    assign hi_th  = $signed({2'b00, MID_CODE}) +
                    $signed({{2{trig_level[SAMPLE_W-1]}}, trig_level});
    assign lo_th  = hi_th - $signed(TH_W'(HYST));
    assign code_s = $signed({2'b00, tick.code});

    // FSM moves only on an enabled tick
    assign step     = tick.valid && enable;
    // Raster outside visible lines
    assign in_blank = (vcount < VBLANK_TOP) || (vcount > VBLANK_BOTTOM);
    assign last     = (addr_cnt == {ADDR_W{1'b1}});
    // Triggering tick or any tick inside a capture gets written
    assign fire     = step && ((state == WAIT_HIGH && code_s >= hi_th && in_blank) ||
                               state == CAPTURE);

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= WAIT_LOW;
            addr_cnt     <= '0;
            wr_en        <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            wr_en        <= fire;
            capture_done <= fire && state == CAPTURE && last;
            // Address wraps to zero after the last entry
            if (fire)
                addr_cnt <= addr_cnt + 1'b1;
            if (step) begin
                case (state)
                    WAIT_LOW:
                        if (code_s <= lo_th)
                            state <= WAIT_HIGH;
                    WAIT_HIGH:
                        // Crossing in the visible area disarms
                        if (code_s >= hi_th)
                            state <= in_blank ? CAPTURE : WAIT_LOW;
                    CAPTURE:
                        if (last)
                            state <= WAIT_LOW;
                    default:
                        state <= WAIT_LOW;
                endcase
            end
        end
    end

    // Write payload, addr_cnt is zero on the triggering tick
    always_ff @(posedge clk) begin
        if (fire) begin
            wr_addr <= addr_cnt;
            wr_code <= tick.code;
        end
    end

    assign wr = '{en: wr_en, addr: wr_addr, code: wr_code};

    // Done only alongside the final buffer write
    a_done_last: assert property (@(posedge clk) disable iff (rst)
        capture_done |-> wr.en && wr.addr == {ADDR_W{1'b1}});

    // Every write traces back to a tick
    a_wr_after_tick: assert property (@(posedge clk) disable iff (rst)
        wr.en |-> $past(tick.valid));

    // Capture runs through the whole buffer
    a_capture_full: assert property (@(posedge clk) disable iff (rst)
        $fell(state == CAPTURE) |-> $past(addr_cnt) == {ADDR_W{1'b1}});

endmodule

`default_nettype wire

// ==== logic/sample_decimator.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_decimator (
    input  logic                            clk,
    input  logic                            rst,
    input  scope_pkg::adc_sample_t          adc,
    input  logic [scope_pkg::SAMPLE_W-1:0]  decim,
    output scope_pkg::adc_sample_t          tick
);

    import scope_pkg::*;

    // Strobe counter runs 0..decim and wraps
    logic [SAMPLE_W-1:0] cnt;
    logic                tick_valid;
    logic [SAMPLE_W-1:0] tick_code;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= '0;
            tick_valid <= 1'b0;
        end else begin
            tick_valid <= 1'b0;
            if (adc.valid) begin
                // Keep the strobe that finds the counter at zero
                tick_valid <= (cnt == '0);
                // Wrap also when decim shrinks below the running count
                if (cnt >= decim)
                    cnt <= '0;
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    // Code of the kept strobe
    always_ff @(posedge clk) begin
        if (adc.valid && cnt == '0)
            tick_code <= adc.code;
    end

    assign tick = '{valid: tick_valid, code: tick_code};

    // Downstream sees at most one tick per strobe
    a_tick_single: assert property (@(posedge clk) disable iff (rst)
        tick.valid |=> !tick.valid);

endmodule

`default_nettype wire

// ==== logic/scope_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module scope_capture #(
    parameter int HYST   = 300,
    parameter int ADDR_W = 8
) (
    input  logic                            clk,
    input  logic                            rst,
    input  scope_pkg::adc_sample_t          adc,
    input  logic                            enable,
    input  logic [scope_pkg::SAMPLE_W-1:0]  decim,
    input  logic signed [scope_pkg::SAMPLE_W-1:0] trig_level,
    input  logic [10:0]                     vcount,
    input  logic [ADDR_W-1:0]               rd_addr,
    output logic [scope_pkg::SAMPLE_W-1:0]  rd_data,
    output logic                            capture_done
);

    import scope_pkg::*;

    // Decimated sample stream
    adc_sample_t tick;
    // Trigger writes into the buffer
    capture_wr_t wr;

    ////////////////////////////////////////////////////////////////////////////
    // Timebase, trigger, memory
    ////////////////////////////////////////////////////////////////////////////

    sample_decimator u_decim (
        .clk   (clk),
        .rst   (rst),
        .adc   (adc),
        .decim (decim),
        .tick  (tick)
    );

    edge_trigger #(
        .HYST   (HYST),
        .ADDR_W (ADDR_W)
    ) u_trig (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .enable       (enable),
        .trig_level   (trig_level),
        .vcount       (vcount),
        .wr           (wr),
        .capture_done (capture_done)
    );

    capture_buffer #(
        .ADDR_W (ADDR_W)
    ) u_buf (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/scope_pkg.sv ====
`default_nettype none

package scope_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // ADC code format
    ////////////////////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 12;

    // Mid-scale code, zero volts at the probe
    localparam logic [SAMPLE_W-1:0] MID_CODE = 12'd2048;

    ////////////////////////////////////////////////////////////////////////////
    // VGA vertical blanking window
    ////////////////////////////////////////////////////////////////////////////

    // Lines above the visible area
    localparam logic [10:0] VBLANK_TOP = 11'd10;
    // Lines below the visible area
    localparam logic [10:0] VBLANK_BOTTOM = 11'd500;

    // One ADC strobe with its code
    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] code;
    } adc_sample_t;

    // Write port from trigger into the capture memory
    typedef struct packed {
        logic                en;
        logic [7:0]          addr;
        logic [SAMPLE_W-1:0] code;
    } capture_wr_t;

    // Trigger FSM, arm below low threshold, fire above high threshold
    typedef enum logic [1:0] {
        WAIT_LOW,
        WAIT_HIGH,
        CAPTURE
    } trig_state_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the scope capture testbench, from the project root

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module scope_capture_tb -f scope_capture.f \
    --Mdir "$OBJ" -o scope_capture_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/scope_capture_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Verdict comes from the log
if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "Simulation log holds no verdict"
    exit 1
fi
exit 0

// ==== scope_capture.f ====
logic/scope_pkg.sv
logic/sample_decimator.sv
logic/edge_trigger.sv
logic/capture_buffer.sv
logic/scope_capture.sv
testbench/scope_capture_tb.sv

// ==== testbench/scope_capture_input.txt ====
# decim trig_level enable vcount kind(0 triangle, 1 noisy square) amplitude period gap count
# last column: expected index of the triggering decimated tick, -1 for no capture

# Low level between thresholds, crossing without a dip first
0   -50  1    5  1  200   64  2   300  -1

# Clean triangle after re-arm, capture in top blanking
0   200  1    5  0  800   64  2   276  20

# Decimated by 4, capture in bottom blanking
3     0  1  600  0  1000 200  2  1076  13

# Noisy square, decimated by 2, slower strobes
1   100  1    0  1  600  100  3   562  25

# Crossings in the visible area only
0     0  1  200  0  600   80  2   400  -1

# Same waveform with the raster in blanking
0     0  1  520  0  600   80  2   276  20

# Trigger disabled, buffer keeps the previous capture
0     0  0    5  0  800   64  2   300  -1

# Negative level, crossing below mid-scale
0  -400  1    3  0  900  100  2   270  14

# Negative level, noisy square, decimated by 3
2  -250  1  700  1  500   90  4   813  15

// ==== testbench/scope_capture_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module scope_capture_tb;

    import scope_pkg::*;

    localparam int HYST      = 300;
    localparam int ADDR_W    = 8;
    localparam int DEPTH     = 2 ** ADDR_W;
    localparam int MAX_CASE  = 32;
    localparam int MAX_SAMP  = 4096;
    localparam int RAMP_LEN  = 8;
    // Noise stays well inside the hysteresis band
    localparam int NOISE_MOD = 64;
    // Pad strobes, re-arm ramp and readback per case
    localparam int CASE_EXTRA = 1000;

    // One line of the input file
    typedef struct packed {
        int decim;
        int level;
        int enable;
        int vcount;
        int kind;
        int amp;
        int period;
        int gap;
        int count;
        int exp_idx;
    } case_t;

    logic                       clk;
    logic                       rst;
    adc_sample_t                adc;
    logic                       enable;
    logic [SAMPLE_W-1:0]        decim;
    logic signed [SAMPLE_W-1:0] trig_level;
    logic [10:0]                vcount;
    logic [ADDR_W-1:0]          rd_addr;
    logic [SAMPLE_W-1:0]        rd_data;
    logic                       capture_done;

    case_t       cases [MAX_CASE];
    int          n_cases = 0;
    int          samples [MAX_SAMP];
    int          seed = 78;
    int          errors = 0;
    int          checks = 0;
    int          budget = 0;
    int          done_seen = 0;

    // Reference model state
    int          m_cnt = 0;
    trig_state_t m_state = WAIT_LOW;
    int          m_addr = 0;
    int          m_mem [DEPTH];
    bit          m_have = 1'b0;
    int          m_done = 0;
    int          m_kept = 0;
    int          m_first = -1;

    scope_capture #(
        .HYST   (HYST),
        .ADDR_W (ADDR_W)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .adc          (adc),
        .enable       (enable),
        .decim        (decim),
        .trig_level   (trig_level),
        .vcount       (vcount),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .capture_done (capture_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Count done pulses, one per high cycle
    always @(negedge clk) begin
        if (!rst && capture_done)
            done_seen <= done_seen + 1;
    end

    // Watchdog, budget set once the cases are known
    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        $display("Timeout: watchdog expired after %0d cycles", budget);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic int clamp_code(input int v);
        if (v < 0)
            return 0;
        if (v > 4095)
            return 4095;
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Input file and waveforms
    ////////////////////////////////////////////////////////////////////////////

    task automatic read_cases;
        int    fd;
        int    r;
        int    n;
        int    f [10];
        string line;
        fd = $fopen("testbench/scope_capture_input.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the input file");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            // Skip comments and blank lines
            if (r > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                if (n == 10 && n_cases < MAX_CASE && f[8] <= MAX_SAMP) begin
                    cases[n_cases] = '{f[0], f[1], f[2], f[3], f[4],
                                       f[5], f[6], f[7], f[8], f[9]};
                    n_cases++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic build_wave(input case_t tc);
        int i;
        int p;
        int v;
        for (i = 0; i < tc.count; i++) begin
            p = i % tc.period;
            if (tc.kind == 0) begin
                // Triangle starting at its minimum
                if (p < tc.period / 2)
                    v = int'(MID_CODE) - tc.amp + 4 * tc.amp * p / tc.period;
                else
                    v = int'(MID_CODE) + tc.amp - 4 * tc.amp * (p - tc.period / 2) / tc.period;
            end else begin
                v = (p < tc.period / 2) ? int'(MID_CODE) - tc.amp : int'(MID_CODE) + tc.amp;
                v = v + $random(seed) % NOISE_MOD;
            end
            samples[i] = clamp_code(v);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and drivers
    ////////////////////////////////////////////////////////////////////////////

    // Decimator and trigger rules, applied per ADC strobe
    task automatic model_strobe(input int code);
        int hi;
        int lo;
        bit kept;
        bit blank;
        hi    = int'(MID_CODE) + int'(trig_level);
        lo    = hi - HYST;
        blank = (vcount < VBLANK_TOP) || (vcount > VBLANK_BOTTOM);
        kept  = (m_cnt == 0);
        m_cnt = (m_cnt == int'(decim)) ? 0 : m_cnt + 1;
        if (kept && enable) begin
            case (m_state)
                WAIT_LOW: begin
                    if (code <= lo)
                        m_state = WAIT_HIGH;
                end
                WAIT_HIGH: begin
                    if (code >= hi && blank) begin
                        m_state  = CAPTURE;
                        m_mem[0] = code;
                        m_addr   = 1;
                        if (m_first < 0)
                            m_first = m_kept;
                    end else if (code >= hi) begin
                        m_state = WAIT_LOW;
                    end
                end
                default: begin
                    m_mem[m_addr] = code;
                    if (m_addr == DEPTH - 1) begin
                        m_state = WAIT_LOW;
                        m_done++;
                        m_have = 1'b1;
                    end
                    m_addr++;
                end
            endcase
        end
        if (kept)
            m_kept++;
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic drive_strobe(input int code, input int period);
        adc.valid = 1'b1;
        adc.code  = code[SAMPLE_W-1:0];
        model_strobe(code);
        @(posedge clk);
        #1;
        adc.valid = 1'b0;
        repeat (period - 1) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Dip below the low threshold, stop short of the high one
    task automatic rearm_ramp(input int hold);
        int lo;
        int k;
        int r;
        lo     = int'(MID_CODE) + int'(trig_level) - HYST;
        enable = 1'b1;
        vcount = (VBLANK_TOP + VBLANK_BOTTOM) / 2;
        for (k = 0; k < RAMP_LEN; k++) begin
            for (r = 0; r <= hold; r++)
                drive_strobe(clamp_code(lo - 60 + 40 * k), 2);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_done_count;
        int waited;
        waited = 0;
        while (done_seen < m_done && waited < 16) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (done_seen < m_done) begin
            $display("Error at %0t: capture_done missing, saw %0d of %0d", $time,
                     done_seen, m_done);
            errors++;
        end
        repeat (4) begin
            @(posedge clk);
            #1;
        end
        if (done_seen > m_done) begin
            $display("Error at %0t: surplus capture_done, saw %0d, expected %0d", $time,
                     done_seen, m_done);
            errors++;
        end
    endtask

    // Pipelined readback, data one cycle behind the address
    task automatic read_back;
        int a;
        for (a = 0; a <= DEPTH; a++) begin
            @(posedge clk);
            #1;
            if (a < DEPTH)
                rd_addr = a[ADDR_W-1:0];
            @(negedge clk);
            if (a > 0) begin
                checks++;
                if (rd_data !== m_mem[a-1][SAMPLE_W-1:0]) begin
                    $display("FAILED at %0t: entry %0d reads %0d, expected %0d", $time,
                             a - 1, rd_data, m_mem[a-1]);
                    errors++;
                end
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_case(input int c);
        case_t tc;
        int    i;
        tc = cases[c];
        // Bring the decimator phase to zero before new settings
        enable = 1'b0;
        while (m_cnt != 0)
            drive_strobe(int'(MID_CODE), 2);
        decim      = tc.decim[SAMPLE_W-1:0];
        trig_level = tc.level[SAMPLE_W-1:0];
        if (c > 0)
            rearm_ramp(tc.decim);
        enable = tc.enable[0];
        vcount = tc.vcount[10:0];
        build_wave(tc);
        m_kept  = 0;
        m_first = -1;
        for (i = 0; i < tc.count; i++)
            drive_strobe(samples[i], tc.gap);
        check_done_count();
        checks++;
        if (m_first != tc.exp_idx) begin
            $display("FAILED at %0t: case %0d trigger tick %0d, file expects %0d", $time,
                     c, m_first, tc.exp_idx);
            errors++;
        end
        if (m_have)
            read_back();
    endtask

    initial begin
        int c;
        int total;
        int max_gap;
        rst        = 1'b1;
        adc        = '0;
        enable     = 1'b0;
        decim      = '0;
        trig_level = '0;
        vcount     = '0;
        rd_addr    = '0;
        read_cases();
        if (n_cases == 0) begin
            $display("Error: no test cases read from the input file");
            errors++;
        end
        total   = 0;
        max_gap = 2;
        for (c = 0; c < n_cases; c++) begin
            total += cases[c].count + CASE_EXTRA;
            if (cases[c].gap > max_gap)
                max_gap = cases[c].gap;
        end
        budget = (total + 100) * max_gap * 2;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (c = 0; c < n_cases; c++)
            run_case(c);
        repeat (4) @(posedge clk);
        $display("Run complete: %0d cases, %0d checks, %0d errors", n_cases, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
